// ==== hdl/tcb_pkg.sv ====
// TCB bus constants, port mode enum, request, response and read-metadata structs
package tcb_pkg;

  ////////////////////
  // bus geometry
  ////////////////////

  // bytes per bus word
  localparam int unsigned tcb_ben = 4;
  // bits per byte lane
  localparam int unsigned tcb_unt = 8;
  // byte address width
  localparam int unsigned tcb_adr_w = 12;
  // lane offset width, address bits below the word
  localparam int unsigned tcb_off_w = $clog2(tcb_ben);
  // word address width
  localparam int unsigned tcb_wadr_w = tcb_adr_w - tcb_off_w;

  ////////////////////
  // port modes
  ////////////////////

  typedef enum logic {
    // data in lanes 0 to size-1, siz is log2 of byte count
    tcb_log_size = 1'b0,
    // data in lane adr%4, requester drives ben
    tcb_byte_ena = 1'b1
  } tcb_mode_t;

  ////////////////////
  // bus records
  ////////////////////

  // request, sampled while its strobe is high
  typedef struct packed {
    logic                         wen;
    logic [tcb_adr_w-1:0]         adr;
    logic [1:0]                   siz;
    logic [tcb_ben-1:0]           ben;
    logic [tcb_ben*tcb_unt-1:0]   wdt;
  } tcb_req_t;

  // response, sts flags a misaligned access
  typedef struct packed {
    logic                         sts;
    logic [tcb_ben*tcb_unt-1:0]   rdt;
  } tcb_rsp_t;

  // what the read side needs to realign data after the delay
  typedef struct packed {
    logic [tcb_off_w-1:0]         off;
    logic [1:0]                   siz;
    logic [tcb_ben-1:0]           ben;
  } tcb_rd_meta_t;

endpackage

// ==== hdl/tcb_mem_ctl.sv ====
// request decode, alignment check and write collision control for both ports
module tcb_mem_ctl #(
  parameter tcb_pkg::tcb_mode_t mod0 = tcb_pkg::tcb_byte_ena,
  parameter tcb_pkg::tcb_mode_t mod1 = tcb_pkg::tcb_log_size
)(
  input  logic                              tcb,
  input  logic                              arst_n,
  // requests
  input  logic                              req0_vld,
  input  tcb_pkg::tcb_req_t                 req0,
  input  logic                              req1_vld,
  input  tcb_pkg::tcb_req_t                 req1,
  // array write control
  output logic                              wen0,
  output logic                              wen1,
  output logic [tcb_pkg::tcb_wadr_w-1:0]    wadr0,
  output logic [tcb_pkg::tcb_wadr_w-1:0]    wadr1,
  output logic [tcb_pkg::tcb_ben-1:0]       mask0,
  output logic [tcb_pkg::tcb_ben-1:0]       mask1,
  // lane metadata and status
  output tcb_pkg::tcb_rd_meta_t             meta0,
  output tcb_pkg::tcb_rd_meta_t             meta1,
  output logic                              sts0,
  output logic                              sts1
);

  // returns {misaligned, byte mask} for one request
  function automatic logic [tcb_pkg::tcb_ben:0] decode(
    input tcb_pkg::tcb_mode_t mod,
    input tcb_pkg::tcb_req_t  req
  );
    logic [tcb_pkg::tcb_ben-1:0]   lanes;
    logic [tcb_pkg::tcb_off_w-1:0] off;
    logic                          mis;
    off = req.adr[tcb_pkg::tcb_off_w-1:0];
    // byte enables already sit in the word lanes
    if (mod == tcb_pkg::tcb_byte_ena) begin
      return {1'b0, req.ben};
    end
    // 2^siz lanes
    // siz 3 does not fit a 32 bit word
    case (req.siz)
      2'd0: begin
        lanes = 4'b0001;
        mis   = 1'b0;
      end
      2'd1: begin
        lanes = 4'b0011;
        mis   = off[0];
      end
      2'd2: begin
        lanes = 4'b1111;
        mis   = |off;
      end
      default: begin
        lanes = 4'b0000;
        mis   = 1'b1;
      end
    endcase
    // misaligned gets an empty mask
    if (mis) begin
      return {1'b1, {tcb_pkg::tcb_ben{1'b0}}};
    end
    return {1'b0, lanes << off};
  endfunction

  // decoded masks before collision handling
  logic [tcb_pkg::tcb_ben-1:0] dec_mask0;
  logic [tcb_pkg::tcb_ben-1:0] dec_mask1;
  // write arming flag
  logic                        wr_arm;
  // same word written by both ports
  logic                        collide;

  ////////////////////
  // write arming
  ////////////////////

  // write enables stay off until the first clock after reset release
  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      wr_arm <= 1'b0;
    end else begin
      wr_arm <= 1'b1;
    end
  end

  ////////////////////
  // decode
  ////////////////////

  assign {sts0, dec_mask0} = decode(mod0, req0);
  assign {sts1, dec_mask1} = decode(mod1, req1);

  // word address
  assign wadr0 = req0.adr[tcb_pkg::tcb_adr_w-1:tcb_pkg::tcb_off_w];
  assign wadr1 = req1.adr[tcb_pkg::tcb_adr_w-1:tcb_pkg::tcb_off_w];

  // misaligned writes are dropped
  assign wen0 = wr_arm & req0_vld & req0.wen & ~sts0;
  assign wen1 = wr_arm & req1_vld & req1.wen & ~sts1;

  ////////////////////
  // collisions
  ////////////////////

  // port 0 owns overlapping bytes
  assign collide = wen0 & wen1 & (wadr0 == wadr1);
  assign mask0   = dec_mask0;
  assign mask1   = collide ? (dec_mask1 & ~dec_mask0) : dec_mask1;

  // read side metadata keeps the uncleared mask
  assign meta0 = '{off: req0.adr[tcb_pkg::tcb_off_w-1:0], siz: req0.siz, ben: dec_mask0};
  assign meta1 = '{off: req1.adr[tcb_pkg::tcb_off_w-1:0], siz: req1.siz, ben: dec_mask1};

endmodule

// ==== hdl/tcb_mem_align.sv ====
// per-port byte lane steering for write data and delayed read data
module tcb_mem_align #(
  parameter tcb_pkg::tcb_mode_t mod = tcb_pkg::tcb_log_size
)(
  // write side, same cycle as the request
  input  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] wdt,
  input  tcb_pkg::tcb_rd_meta_t                              wmeta,
  output logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] wdt_lane,
  // read side, after the delay line
  input  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] rdt_raw,
  input  tcb_pkg::tcb_rd_meta_t                              rmeta,
  output logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] rdt
);

  ////////////////////
  // write lanes
  ////////////////////

  always_comb begin
    for (int b = 0; b < tcb_pkg::tcb_ben; b++) begin
      if (mod == tcb_pkg::tcb_log_size) begin
        // rotate up, lane b takes byte b-off
        wdt_lane[b] = wdt[(b + tcb_pkg::tcb_ben - int'(wmeta.off)) % tcb_pkg::tcb_ben];
      end else begin
        // byte-enable data is already in place
        wdt_lane[b] = wdt[b];
      end
    end
  end

  ////////////////////
  // read lanes
  ////////////////////

  always_comb begin
    for (int b = 0; b < tcb_pkg::tcb_ben; b++) begin
      if (mod == tcb_pkg::tcb_log_size) begin
        // rotate down, byte b comes from lane b+off
        rdt[b] = rdt_raw[(b + int'(rmeta.off)) % tcb_pkg::tcb_ben];
      end else begin
        // disabled lanes read as zero
        rdt[b] = rmeta.ben[b] ? rdt_raw[b] : '0;
      end
    end
  end

endmodule

// ==== hdl/tcb_mem_array.sv ====
// dual-port word array, byte masked writes and combinational reads
module tcb_mem_array #(
  parameter int unsigned dep = 256
)(
  input  logic                                               tcb,
  // word addresses
  input  logic [tcb_pkg::tcb_wadr_w-1:0]                    adr0,
  input  logic [tcb_pkg::tcb_wadr_w-1:0]                    adr1,
  // write control
  input  logic                                               wen0,
  input  logic                                               wen1,
  input  logic [tcb_pkg::tcb_ben-1:0]                       mask0,
  input  logic [tcb_pkg::tcb_ben-1:0]                       mask1,
  // write data, already in word lanes
  input  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] wdt0,
  input  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] wdt1,
  // raw read words
  output logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] rdt0,
  output logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] rdt1
);

  // index width for the configured depth
  localparam int unsigned aw = $clog2(dep);

  // storage, one packed word per entry
  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] mem [dep];

  // array indices
  logic [aw-1:0] idx0;
  logic [aw-1:0] idx1;

  // upper address bits wrap onto the array
  assign idx0 = adr0[aw-1:0];
  assign idx1 = adr1[aw-1:0];

  ////////////////////
  // write
  ////////////////////

  always_ff @(posedge tcb) begin
    // port 1 first
    for (int b = 0; b < tcb_pkg::tcb_ben; b++) begin
      if (wen1 && mask1[b]) begin
        mem[idx1][b] <= wdt1[b];
      end
    end
    // port 0 last so it wins a shared byte
    for (int b = 0; b < tcb_pkg::tcb_ben; b++) begin
      if (wen0 && mask0[b]) begin
        mem[idx0][b] <= wdt0[b];
      end
    end
  end

  ////////////////////
  // read
  ////////////////////

  // old data when written in the same cycle
  assign rdt0 = mem[idx0];
  assign rdt1 = mem[idx1];

endmodule

// ==== hdl/tcb_delay_line.sv ====
// fixed latency pipeline with a strobe and a generic payload
module tcb_delay_line #(
  parameter int unsigned dly = 2,
  parameter type payload_t = logic
)(
  input  logic     tcb,
  input  logic     arst_n,
  // input side
  input  logic     vld_i,
  input  payload_t dat_i,
  // output side, dly cycles later
  output logic     vld_o,
  output payload_t dat_o
);

  // strobe stages
  logic [dly-1:0] vld_q;
  // payload stages
  payload_t       dat_q [dly];

  ////////////////////
  // strobe
  ////////////////////

  always_ff @(posedge tcb or negedge arst_n) begin
    if (!arst_n) begin
      vld_q <= '0;
    end else begin
      vld_q[0] <= vld_i;
      for (int i = 1; i < dly; i++) begin
        vld_q[i] <= vld_q[i-1];
      end
    end
  end

  ////////////////////
  // payload
  ////////////////////

  // each stage loads only behind a valid strobe
  always_ff @(posedge tcb) begin
    if (vld_i) begin
      dat_q[0] <= dat_i;
    end
    for (int i = 1; i < dly; i++) begin
      if (vld_q[i-1]) begin
        dat_q[i] <= dat_q[i-1];
      end
    end
  end

  // last stage
  assign vld_o = vld_q[dly-1];
  assign dat_o = dat_q[dly-1];

endmodule

// ==== hdl/tcb_mem_top.sv ====
// two-port TCB memory top, control, aligners, word array and read delay lines
module tcb_mem_top #(
  parameter int unsigned        dly  = 2,
  parameter int unsigned        dep  = 256,
  parameter tcb_pkg::tcb_mode_t mod0 = tcb_pkg::tcb_byte_ena,
  parameter tcb_pkg::tcb_mode_t mod1 = tcb_pkg::tcb_log_size
)(
  input  logic              tcb,
  input  logic              arst_n,
  // port 0
  input  logic              req0_vld,
  input  tcb_pkg::tcb_req_t req0,
  output logic              rsp0_vld,
  output tcb_pkg::tcb_rsp_t rsp0,
  // port 1
  input  logic              req1_vld,
  input  tcb_pkg::tcb_req_t req1,
  output logic              rsp1_vld,
  output tcb_pkg::tcb_rsp_t rsp1
);

  // control outputs
  logic                                               wen0;
  logic                                               wen1;
  logic [tcb_pkg::tcb_wadr_w-1:0]                    wadr0;
  logic [tcb_pkg::tcb_wadr_w-1:0]                    wadr1;
  logic [tcb_pkg::tcb_ben-1:0]                       mask0;
  logic [tcb_pkg::tcb_ben-1:0]                       mask1;
  tcb_pkg::tcb_rd_meta_t                              meta0;
  tcb_pkg::tcb_rd_meta_t                              meta1;
  logic                                               sts0;
  logic                                               sts1;
  // lane positioned write data
  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] wdt_lane0;
  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] wdt_lane1;
  // raw array words
  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] rdt_arr0;
  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] rdt_arr1;
  // delay line inputs and outputs
  tcb_pkg::tcb_rsp_t                                  raw0;
  tcb_pkg::tcb_rsp_t                                  raw1;
  tcb_pkg::tcb_rsp_t                                  raw0_dly;
  tcb_pkg::tcb_rsp_t                                  raw1_dly;
  tcb_pkg::tcb_rd_meta_t                              meta0_dly;
  tcb_pkg::tcb_rd_meta_t                              meta1_dly;
  // realigned read data
  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] rdt0;
  logic [tcb_pkg::tcb_ben-1:0][tcb_pkg::tcb_unt-1:0] rdt1;

  ////////////////////
  // control
  ////////////////////

  tcb_mem_ctl #(.mod0(mod0), .mod1(mod1)) ctl (
    .tcb(tcb), .arst_n(arst_n),
    .req0_vld(req0_vld), .req0(req0), .req1_vld(req1_vld), .req1(req1),
    .wen0(wen0), .wen1(wen1), .wadr0(wadr0), .wadr1(wadr1),
    .mask0(mask0), .mask1(mask1), .meta0(meta0), .meta1(meta1),
    .sts0(sts0), .sts1(sts1)
  );

  ////////////////////
  // lane steering
  ////////////////////

  tcb_mem_align #(.mod(mod0)) align0 (
    .wdt(req0.wdt), .wmeta(meta0), .wdt_lane(wdt_lane0),
    .rdt_raw(raw0_dly.rdt), .rmeta(meta0_dly), .rdt(rdt0)
  );

  tcb_mem_align #(.mod(mod1)) align1 (
    .wdt(req1.wdt), .wmeta(meta1), .wdt_lane(wdt_lane1),
    .rdt_raw(raw1_dly.rdt), .rmeta(meta1_dly), .rdt(rdt1)
  );

  ////////////////////
  // storage
  ////////////////////

  tcb_mem_array #(.dep(dep)) array (
    .tcb(tcb),
    .adr0(wadr0), .adr1(wadr1), .wen0(wen0), .wen1(wen1),
    .mask0(mask0), .mask1(mask1), .wdt0(wdt_lane0), .wdt1(wdt_lane1),
    .rdt0(rdt_arr0), .rdt1(rdt_arr1)
  );

  ////////////////////
  // read delay
  ////////////////////

  // raw word and status enter the pipe together
  assign raw0 = '{sts: sts0, rdt: rdt_arr0};
  assign raw1 = '{sts: sts1, rdt: rdt_arr1};

  tcb_delay_line #(.dly(dly), .payload_t(tcb_pkg::tcb_rsp_t)) dly_rsp0 (
    .tcb(tcb), .arst_n(arst_n),
    .vld_i(req0_vld), .dat_i(raw0), .vld_o(rsp0_vld), .dat_o(raw0_dly)
  );

  tcb_delay_line #(.dly(dly), .payload_t(tcb_pkg::tcb_rsp_t)) dly_rsp1 (
    .tcb(tcb), .arst_n(arst_n),
    .vld_i(req1_vld), .dat_i(raw1), .vld_o(rsp1_vld), .dat_o(raw1_dly)
  );

  // metadata strobe tracks the response strobe, left open
  tcb_delay_line #(.dly(dly), .payload_t(tcb_pkg::tcb_rd_meta_t)) dly_meta0 (
    .tcb(tcb), .arst_n(arst_n),
    .vld_i(req0_vld), .dat_i(meta0), .vld_o(), .dat_o(meta0_dly)
  );

  tcb_delay_line #(.dly(dly), .payload_t(tcb_pkg::tcb_rd_meta_t)) dly_meta1 (
    .tcb(tcb), .arst_n(arst_n),
    .vld_i(req1_vld), .dat_i(meta1), .vld_o(), .dat_o(meta1_dly)
  );

  // responses in port lane convention
  assign rsp0 = '{sts: raw0_dly.sts, rdt: rdt0};
  assign rsp1 = '{sts: raw1_dly.sts, rdt: rdt1};

endmodule

// ==== testbench/tcb_mem_props.sv ====
// concurrent assertions on response strobes and status, bound to the memory top
module tcb_mem_props #(
  parameter int unsigned dly = 2
)(
  input logic              tcb,
  input logic              arst_n,
  input logic              req0_vld,
  input logic              req1_vld,
  input logic              rsp0_vld,
  input logic              rsp1_vld,
  input tcb_pkg::tcb_rsp_t rsp0
);

  // failed assertion count
  int fail_cnt = 0;

  ////////////////////
  // latency
  ////////////////////

  // response strobe is the request strobe dly cycles later
  rsp0_latency: assert property (@(posedge tcb) disable iff (!arst_n)
    rsp0_vld == $past(req0_vld, dly))
  else begin
    $error("rsp0_vld does not follow req0_vld by dly cycles");
    fail_cnt++;
  end

  rsp1_latency: assert property (@(posedge tcb) disable iff (!arst_n)
    rsp1_vld == $past(req1_vld, dly))
  else begin
    $error("rsp1_vld does not follow req1_vld by dly cycles");
    fail_cnt++;
  end

  ////////////////////
  // reset and status
  ////////////////////

  // no responses while reset is held
  rsp_quiet_in_reset: assert property (@(posedge tcb) !arst_n |-> !rsp0_vld && !rsp1_vld)
  else begin
    $error("response strobe high during reset");
    fail_cnt++;
  end

  // byte-enable port is never misaligned
  rsp0_no_sts: assert property (@(posedge tcb) disable iff (!arst_n) rsp0_vld |-> !rsp0.sts)
  else begin
    $error("status set on a port 0 response");
    fail_cnt++;
  end

endmodule

// attach to every instance of the memory top
bind tcb_mem_top tcb_mem_props #(.dly(dly)) props (
  .tcb(tcb), .arst_n(arst_n),
  .req0_vld(req0_vld), .req1_vld(req1_vld),
  .rsp0_vld(rsp0_vld), .rsp1_vld(rsp1_vld), .rsp0(rsp0)
);

// ==== testbench/tcb_mem_tb.sv ====
// testbench top with clock, reset, stimulus table, shadow memory, response checks and timeout
module tcb_mem_tb;

  localparam int unsigned dly      = 2;
  localparam int unsigned fill_len = 16;

  // one table row, both requests and their expected responses
  typedef struct packed {
    logic              vld0;
    tcb_pkg::tcb_req_t req0;
    logic              vld1;
    tcb_pkg::tcb_req_t req1;
    tcb_pkg::tcb_rsp_t exp0;
    logic [3:0]        msk0;
    tcb_pkg::tcb_rsp_t exp1;
    logic [3:0]        msk1;
  } entry_t;

  // response still outstanding, with its request cycle
  typedef struct packed {
    tcb_pkg::tcb_rsp_t rsp;
    logic [3:0]        msk;
    int                cyc;
  } pend_t;

  localparam tcb_pkg::tcb_req_t idle = '0;

  logic              tcb;
  logic              arst_n;
  logic              req0_vld;
  tcb_pkg::tcb_req_t req0;
  logic              req1_vld;
  tcb_pkg::tcb_req_t req1;
  logic              rsp0_vld;
  tcb_pkg::tcb_rsp_t rsp0;
  logic              rsp1_vld;
  tcb_pkg::tcb_rsp_t rsp1;

  // stimulus table and the row on the bus
  entry_t     tbl [$];
  entry_t     row;
  // expected responses per port
  pend_t      q0 [$];
  pend_t      q1 [$];
  // byte image of the 16 tested words
  logic [7:0] shadow [64];
  int         seed    = 58;
  int         errors  = 0;
  int         cyc     = 0;
  int         run_cyc = 0;
  int         limit   = 0;

  tcb_mem_top #(
    .dly(dly), .dep(256), .mod0(tcb_pkg::tcb_byte_ena), .mod1(tcb_pkg::tcb_log_size)
  ) DUT (
    .tcb(tcb), .arst_n(arst_n),
    .req0_vld(req0_vld), .req0(req0), .rsp0_vld(rsp0_vld), .rsp0(rsp0),
    .req1_vld(req1_vld), .req1(req1), .rsp1_vld(rsp1_vld), .rsp1(rsp1)
  );

  always #4 tcb = ~tcb;

  ////////////////////
  // helpers
  ////////////////////

  // byte lanes to bit mask
  function automatic logic [31:0] lane_bits(input logic [3:0] m);
    logic [31:0] r;
    for (int b = 0; b < 4; b++) begin
      r[8*b +: 8] = {8{m[b]}};
    end
    return r;
  endfunction

  function automatic tcb_pkg::tcb_req_t make_req(input logic wen, input int adr, input int siz,
                                                  input logic [3:0] ben, input logic [31:0] wdt);
    tcb_pkg::tcb_req_t r;
    r.wen = wen;
    r.adr = 12'(adr);
    r.siz = 2'(siz);
    r.ben = ben;
    r.wdt = wdt;
    return r;
  endfunction

  // masked compare
  task automatic check(input string name, input logic [31:0] act, input logic [31:0] exp,
                       input logic [31:0] msk);
    if ((act & msk) !== (exp & msk)) begin
      $display("FAILED %s: got %h, expected %h", name, act & msk, exp & msk);
      errors++;
    end
  endtask

  // predict both responses from the shadow, then apply the writes
  task automatic add_entry(input logic v0, input tcb_pkg::tcb_req_t r0,
                           input logic v1, input tcb_pkg::tcb_req_t r1);
    entry_t e;
    int     a;
    int     n;
    e = '0;
    e.vld0 = v0;
    e.req0 = r0;
    e.vld1 = v1;
    e.req1 = r1;
    // byte-enable port sees its word in place
    a = int'(r0.adr) & ~3;
    for (int b = 0; b < 4; b++) begin
      e.exp0.rdt[8*b +: 8] = shadow[6'(a + b)];
    end
    e.msk0 = r0.wen ? 4'b0000 : r0.ben;
    // log-size port, aligned when adr is a multiple of the byte count
    a = int'(r1.adr);
    n = 1 << r1.siz;
    e.exp1.sts = (a % n) != 0;
    e.msk1 = (e.exp1.sts || r1.wen) ? 4'b0000 : 4'((1 << n) - 1);
    for (int i = 0; i < n; i++) begin
      e.exp1.rdt[8*i +: 8] = shadow[6'(a + i)];
    end
    // port 1 lands first, port 0 owns shared bytes
    if (v1 && r1.wen && !e.exp1.sts) begin
      for (int i = 0; i < n; i++) begin
        shadow[6'(a + i)] = r1.wdt[8*i +: 8];
      end
    end
    a = int'(r0.adr) & ~3;
    for (int b = 0; b < 4; b++) begin
      if (v0 && r0.wen && r0.ben[b]) begin
        shadow[6'(a + b)] = r0.wdt[8*b +: 8];
      end
    end
    tbl.push_back(e);
  endtask

  ////////////////////
  // stimulus table
  ////////////////////

  task automatic build_table();
    // fill words 0 to 15
    for (int w = 0; w < fill_len; w++) begin
      add_entry(1'b1, make_req(1'b1, 4*w, 2, 4'hf, $random(seed)), 1'b0, idle);
    end
    // partial byte-enable writes, then full reads
    add_entry(1'b1, make_req(1'b1, 4, 2, 4'b0011, 32'h0000_a1b2), 1'b0, idle);
    add_entry(1'b1, make_req(1'b1, 8, 2, 4'b1000, 32'hc300_0000), 1'b0, idle);
    add_entry(1'b1, make_req(1'b1, 12, 2, 4'b0110, 32'h00d4_e500), 1'b0, idle);
    add_entry(1'b1, make_req(1'b0, 4, 2, 4'hf, '0), 1'b0, idle);
    add_entry(1'b1, make_req(1'b0, 8, 2, 4'hf, '0), 1'b0, idle);
    add_entry(1'b1, make_req(1'b0, 12, 2, 4'hf, '0), 1'b0, idle);
    // log-size writes of 1, 2 and 4 bytes
    add_entry(1'b0, idle, 1'b1, make_req(1'b1, 17, 0, 4'h0, 32'h0000_005a));
    add_entry(1'b0, idle, 1'b1, make_req(1'b1, 22, 1, 4'h0, 32'h0000_7e6f));
    add_entry(1'b0, idle, 1'b1, make_req(1'b1, 24, 2, 4'h0, 32'h1234_5678));
    add_entry(1'b1, make_req(1'b0, 16, 2, 4'hf, '0), 1'b1, make_req(1'b0, 17, 0, 4'h0, '0));
    add_entry(1'b1, make_req(1'b0, 20, 2, 4'hf, '0), 1'b1, make_req(1'b0, 22, 1, 4'h0, '0));
    add_entry(1'b1, make_req(1'b0, 24, 2, 4'hf, '0), 1'b1, make_req(1'b0, 24, 2, 4'h0, '0));
    // misaligned log-size accesses leave memory alone
    add_entry(1'b0, idle, 1'b1, make_req(1'b1, 33, 1, 4'h0, 32'h0000_ffff));
    add_entry(1'b0, idle, 1'b1, make_req(1'b1, 38, 2, 4'h0, 32'hdead_beef));
    add_entry(1'b1, make_req(1'b0, 32, 2, 4'hf, '0), 1'b1, make_req(1'b0, 35, 1, 4'h0, '0));
    add_entry(1'b1, make_req(1'b0, 36, 2, 4'hf, '0), 1'b0, idle);
    // same word from both ports
    add_entry(1'b1, make_req(1'b1, 40, 2, 4'b0110, 32'h0011_2200),
              1'b1, make_req(1'b1, 40, 2, 4'h0, 32'haabb_ccdd));
    add_entry(1'b1, make_req(1'b0, 40, 2, 4'hf, '0), 1'b1, make_req(1'b0, 40, 2, 4'h0, '0));
    // back to back on both ports, read beside write gets old data
    add_entry(1'b1, make_req(1'b1, 48, 2, 4'hf, 32'h0102_0304),
              1'b1, make_req(1'b0, 48, 2, 4'h0, '0));
    add_entry(1'b1, make_req(1'b0, 48, 2, 4'hf, '0), 1'b1, make_req(1'b0, 48, 2, 4'h0, '0));
    add_entry(1'b1, make_req(1'b1, 52, 2, 4'b1100, 32'h0b0c_0000),
              1'b1, make_req(1'b1, 56, 0, 4'h0, 32'h0000_0077));
    add_entry(1'b1, make_req(1'b0, 56, 2, 4'b0001, '0), 1'b1, make_req(1'b0, 54, 1, 4'h0, '0));
    add_entry(1'b1, make_req(1'b1, 60, 2, 4'b0001, 32'h0000_00e1),
              1'b1, make_req(1'b0, 60, 0, 4'h0, '0));
    add_entry(1'b1, make_req(1'b0, 60, 2, 4'hf, '0), 1'b1, make_req(1'b0, 60, 0, 4'h0, '0));
    add_entry(1'b1, make_req(1'b0, 52, 2, 4'hf, '0),
              1'b1, make_req(1'b1, 62, 1, 4'h0, 32'h0000_9988));
    add_entry(1'b1, make_req(1'b0, 56, 2, 4'hf, '0), 1'b1, make_req(1'b0, 60, 2, 4'h0, '0));
  endtask

  ////////////////////
  // response side
  ////////////////////

  task automatic match_rsp(input int port, input tcb_pkg::tcb_rsp_t rsp);
    pend_t p;
    if ((port == 0 && q0.size() == 0) || (port == 1 && q1.size() == 0)) begin
      $display("port %0d returned a response that no request asked for", port);
      errors++;
      return;
    end
    if (port == 0) begin
      p = q0.pop_front();
    end else begin
      p = q1.pop_front();
    end
    if (cyc - p.cyc != int'(dly)) begin
      $display("port %0d response came %0d cycles after its request", port, cyc - p.cyc);
      errors++;
    end
    check($sformatf("rsp%0d.sts", port), {31'd0, rsp.sts}, {31'd0, p.rsp.sts}, 32'h1);
    check($sformatf("rsp%0d.rdt", port), rsp.rdt, p.rsp.rdt, lane_bits(p.msk));
  endtask

  // outputs settle between edges
  always @(negedge tcb) begin
    if (arst_n) begin
      if (rsp0_vld) begin
        match_rsp(0, rsp0);
      end
      if (rsp1_vld) begin
        match_rsp(1, rsp1);
      end
      if (req0_vld) begin
        q0.push_back(pend_t'{rsp: row.exp0, msk: row.msk0, cyc: cyc});
      end
      if (req1_vld) begin
        q1.push_back(pend_t'{rsp: row.exp1, msk: row.msk1, cyc: cyc});
      end
      cyc++;
    end
  end

  task automatic finish_run();
    int total;
    total = errors + DUT.props.fail_cnt;
    $display("errors: %0d in checks, %0d in assertions", errors, DUT.props.fail_cnt);
    if (total == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  endtask

  // watchdog
  always @(posedge tcb) begin
    if (arst_n) begin
      run_cyc++;
      if (run_cyc > limit) begin
        $display("timeout, run did not finish within %0d cycles", limit);
        errors++;
        finish_run();
      end
    end
  end

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    tcb      = 1'b0;
    arst_n   = 1'b0;
    req0_vld = 1'b0;
    req0     = idle;
    req1_vld = 1'b0;
    req1     = idle;
    row      = '0;
    build_table();
    // fill rows are part of the table
    limit = tbl.size() + dly + 50;
    repeat (16) @(posedge tcb);
    arst_n <= 1'b1;
    @(posedge tcb);
    foreach (tbl[i]) begin
      req0_vld <= tbl[i].vld0;
      req0     <= tbl[i].req0;
      req1_vld <= tbl[i].vld1;
      req1     <= tbl[i].req1;
      row      <= tbl[i];
      @(posedge tcb);
    end
    req0_vld <= 1'b0;
    req1_vld <= 1'b0;
    // drain outstanding responses
    while (q0.size() != 0 || q1.size() != 0) begin
      @(negedge tcb);
    end
    // a few idle cycles to catch a stray response
    repeat (dly + 2) @(negedge tcb);
    finish_run();
  end

endmodule

// ==== tcb_mem.f ====
hdl/tcb_pkg.sv
hdl/tcb_mem_ctl.sv
hdl/tcb_mem_align.sv
hdl/tcb_mem_array.sv
hdl/tcb_delay_line.sv
hdl/tcb_mem_top.sv
testbench/tcb_mem_props.sv
testbench/tcb_mem_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the TCB memory testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tcb_mem_tb -f tcb_mem.f --Mdir obj_dir -o tcb_mem_sim

# keep running past assertion errors so the testbench prints its verdict
./obj_dir/tcb_mem_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

# verdict comes from the log
if grep -q "^TESTBENCH PASSED$" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi
